// ==== loadStoreUnit.f ====
source/memPkg.sv
source/lsuPkg.sv
source/dataMemory.sv
source/byteLaneAligner.sv
source/writebackBuffer.sv
source/lsuControl.sv
source/loadStoreUnit.sv
verif/clockGen.sv
verif/loadStoreUnitTb.sv

// ==== Bender.yml ====
package:
  name: loadStoreUnit

sources:
  # Packages first, then the datapath, controller and top level
  - source/memPkg.sv
  - source/lsuPkg.sv
  - source/dataMemory.sv
  - source/byteLaneAligner.sv
  - source/writebackBuffer.sv
  - source/lsuControl.sv
  - source/loadStoreUnit.sv
  - target: test
    files:
      - verif/clockGen.sv
      - verif/loadStoreUnitTb.sv

// ==== verif/loadStoreUnitTb.sv ====
module loadStoreUnitTb
    import memPkg::*;
    import lsuPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RegAddrWidth = 4;
    localparam int AddrWidth    = 10;
    localparam int Timeout      = 200;
    localparam int BpLength     = 1024;

    logic                    clk;
    logic                    arstN;
    logic                    reqValid;
    logic                    reqReady;
    minorOpT                 reqOp;
    logic [RegAddrWidth-1:0] reqDest;
    logic [AddrWidth-1:0]    reqAddr;
    dataWordT                reqData;
    logic                    flashEn;
    logic [AddrWidth-1:0]    flashAddr;
    dataWordT                flashData;
    logic                    wbValid;
    logic                    wbReady;
    logic [RegAddrWidth-1:0] wbDest;
    dataWordT                wbData;

    // Reference memory and expected writebacks in issue order
    dataWordT                model [MemWords];
    dataWordT                expDataQ [$];
    logic [RegAddrWidth-1:0] expDestQ [$];
    logic [RegAddrWidth-1:0] nextDest;

    logic                    bpPattern [BpLength];
    logic                    bpMode;
    int                      checkCount;
    int                      errorCount;

    clockGen i_clockGen (
        .clk  (clk),
        .arstN(arstN)
    );

    loadStoreUnit #(
        .RegAddrWidth(RegAddrWidth),
        .AddrWidth   (AddrWidth)
    ) i_dut (
        .clk      (clk),
        .arstN    (arstN),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .reqOp    (reqOp),
        .reqDest  (reqDest),
        .reqAddr  (reqAddr),
        .reqData  (reqData),
        .flashEn  (flashEn),
        .flashAddr(flashAddr),
        .flashData(flashData),
        .wbValid  (wbValid),
        .wbReady  (wbReady),
        .wbDest   (wbDest),
        .wbData   (wbData)
    );

    task automatic compareData(input string name, input dataWordT got, input dataWordT exp);
        checkCount++;
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%04h expected 0x%04h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic compareDest(input string name, input logic [RegAddrWidth-1:0] got,
                               input logic [RegAddrWidth-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            errorCount++;
        end
    endtask

    // Load result: byte lane 1 is the high byte, bytes are zero-extended
    function automatic dataWordT expectedLoad(input minorOpT op, input logic [AddrWidth-1:0] addr);
        dataWordT word;
        word = model[addr[AddrWidth-1:1]];
        if (op[1:0] == 2'b01) begin
            return word;
        end else if (op[1:0] != 2'b00) begin
            return 16'hFFFF;
        end
        return addr[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
    endfunction

    // Store merges the low data byte into the addressed lane
    task automatic storeModel(input minorOpT op, input logic [AddrWidth-1:0] addr,
                              input dataWordT data);
        logic [AddrWidth-2:0] idx;
        idx = addr[AddrWidth-1:1];
        case (op[1:0])
            2'b00: begin
                if (addr[0]) begin
                    model[idx][15:8] = data[7:0];
                end else begin
                    model[idx][7:0] = data[7:0];
                end
            end
            2'b01:   model[idx] = data;
            default: model[idx] = 16'hFFFF;
        endcase
    endtask

    task automatic issueRequest(input minorOpT op, input logic [AddrWidth-1:0] addr,
                                input dataWordT data);
        int waitCycles;
        bit accepted;
        @(negedge clk);
        reqValid = 1'b1;
        reqOp    = op;
        reqDest  = nextDest;
        reqAddr  = addr;
        reqData  = data;
        waitCycles = 0;
        accepted   = 1'b0;
        while (!accepted && waitCycles < Timeout) begin
            @(posedge clk);
            if (reqReady) begin
                accepted = 1'b1;
            end
            waitCycles++;
        end
        if (!accepted) begin
            $display("Timeout: request was not accepted within %0d cycles", Timeout);
            errorCount++;
        end else if (op[3:2] == 2'b01) begin
            storeModel(op, addr, data);
        end else begin
            expDataQ.push_back(expectedLoad(op, addr));
            expDestQ.push_back(nextDest);
            nextDest++;
        end
    endtask

    task automatic flashWord(input logic [AddrWidth-1:0] addr, input dataWordT data);
        @(negedge clk);
        flashEn   = 1'b1;
        flashAddr = addr;
        flashData = data;
        model[addr[AddrWidth-1:1]] = data;
    endtask

    // Drop the request and wait until every expected load has come back
    task automatic drainWriteback();
        int waitCycles;
        @(negedge clk);
        reqValid   = 1'b0;
        waitCycles = 0;
        while (expDataQ.size() != 0 && waitCycles < Timeout) begin
            @(negedge clk);
            waitCycles++;
        end
        if (expDataQ.size() != 0) begin
            $display("Timeout: %0d load results never reached writeback", expDataQ.size());
            errorCount++;
            expDataQ.delete();
            expDestQ.delete();
        end
    endtask

    task automatic reportTest(input int num, input string name, input int errsBefore);
        if (errorCount == errsBefore) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, errorCount - errsBefore);
        end
    endtask

    // Writeback stage ready, random pattern only while back-pressure is on
    initial begin
        int cycleIdx;
        cycleIdx = 0;
        wbReady  = 1'b1;
        forever begin
            @(negedge clk);
            wbReady  = bpMode ? bpPattern[cycleIdx % BpLength] : 1'b1;
            cycleIdx++;
        end
    end

    // Every writeback transfer is checked against the oldest expected load
    always @(posedge clk) begin
        if (arstN && wbValid && wbReady) begin
            if (expDataQ.size() == 0) begin
                $display("Writeback transfer arrived with no load outstanding");
                errorCount++;
            end else begin
                compareDest("wbDest", wbDest, expDestQ.pop_front());
                compareData("wbData", wbData, expDataQ.pop_front());
            end
        end
    end

    initial begin
        int                   errsBefore;
        int                   waitCycles;
        int                   pick;
        logic [AddrWidth-1:0] addr;
        dataWordT             data;

        reqValid   = 1'b0;
        reqOp      = opLoadByte;
        reqDest    = '0;
        reqAddr    = '0;
        reqData    = '0;
        flashEn    = 1'b0;
        flashAddr  = '0;
        flashData  = '0;
        bpMode     = 1'b0;
        nextDest   = '0;
        checkCount = 0;
        errorCount = 0;

        void'($urandom(32'he8e031a9));
        for (int i = 0; i < BpLength; i++) begin
            bpPattern[i] = ($urandom % 3) != 0;
        end

        // Reset values, then ready
        errsBefore = errorCount;
        waitCycles = 0;
        while (arstN !== 1'b1 && waitCycles < Timeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (arstN !== 1'b1) begin
            $display("Timeout: reset was never released");
            errorCount++;
        end
        @(negedge clk);
        compareFlag("wbValid", wbValid, 1'b0);
        waitCycles = 0;
        while (reqReady !== 1'b1 && waitCycles < Timeout) begin
            @(negedge clk);
            waitCycles++;
        end
        if (reqReady !== 1'b1) begin
            $display("Timeout: reqReady never rose after reset");
            errorCount++;
        end
        reportTest(1, "reset", errsBefore);

        // Flash the whole memory and read it back
        errsBefore = errorCount;
        for (int i = 0; i < MemWords; i++) begin
            flashWord(AddrWidth'(i * 2), dataWordT'($urandom));
        end
        @(negedge clk);
        flashEn = 1'b0;
        for (int i = 0; i < MemWords; i++) begin
            issueRequest(opLoadWord, AddrWidth'(i * 2), '0);
        end
        drainWriteback();
        reportTest(2, "flash and load", errsBefore);

        errsBefore = errorCount;
        for (int i = 0; i < 32; i++) begin
            addr = AddrWidth'($urandom_range(0, MemWords - 1) * 2);
            issueRequest(opLoadByte, addr, '0);
            issueRequest(opLoadByte, addr | AddrWidth'(1), '0);
        end
        drainWriteback();
        reportTest(3, "byte loads", errsBefore);

        // Loads right behind stores see the merged word
        errsBefore = errorCount;
        for (int i = 0; i < 16; i++) begin
            addr = AddrWidth'($urandom_range(0, 2 * MemWords - 1));
            issueRequest(opStoreByte, addr, dataWordT'($urandom));
            issueRequest(opLoadByte, addr, '0);
            issueRequest(opLoadWord, {addr[AddrWidth-1:1], 1'b0}, '0);
            addr = {addr[AddrWidth-1:1], 1'b0};
            issueRequest(opStoreWord, addr, dataWordT'($urandom));
            issueRequest(opLoadWord, addr, '0);
            issueRequest(opLoadByte, addr | AddrWidth'(1), '0);
        end
        drainWriteback();
        reportTest(4, "store then load", errsBefore);

        // Random traffic on a small address window under back-pressure
        errsBefore = errorCount;
        bpMode = 1'b1;
        for (int i = 0; i < 200; i++) begin
            pick = $urandom % 4;
            addr = AddrWidth'($urandom_range(0, 63));
            data = dataWordT'($urandom);
            case (pick)
                0: issueRequest(opLoadByte, addr, data);
                1: issueRequest(opLoadWord, {addr[AddrWidth-1:1], 1'b0}, data);
                2: issueRequest(opStoreByte, addr, data);
                default: issueRequest(opStoreWord, {addr[AddrWidth-1:1], 1'b0}, data);
            endcase
        end
        drainWriteback();
        bpMode = 1'b0;
        reportTest(5, "back-pressure mix", errsBefore);

        errsBefore = errorCount;
        addr = AddrWidth'($urandom_range(0, MemWords - 1) * 2);
        issueRequest(opStoreDouble, addr, dataWordT'($urandom));
        issueRequest(opLoadWord, addr, '0);
        addr = AddrWidth'($urandom_range(0, MemWords - 1) * 2);
        issueRequest(opStoreQuad, addr, dataWordT'($urandom));
        issueRequest(opLoadWord, addr, '0);
        addr = AddrWidth'($urandom_range(0, MemWords - 1) * 2);
        issueRequest(opLoadDouble, addr, '0);
        issueRequest(opLoadQuad, addr, '0);
        drainWriteback();
        reportTest(6, "double and quad", errsBefore);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic arstN
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime HalfPeriod = 5ns;

    // Free running 10 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #(HalfPeriod);
            clk = ~clk;
        end
    end

    // Reset held over two rising edges, released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// ==== source/loadStoreUnit.sv ====
module loadStoreUnit
    import memPkg::*;
    import lsuPkg::*;
#(
    parameter int RegAddrWidth = 4,
    parameter int AddrWidth    = 10
) (
    input  logic                    clk,
    input  logic                    arstN,

    // Request handshake from execute
    input  logic                    reqValid,
    output logic                    reqReady,
    input  minorOpT                 reqOp,
    input  logic [RegAddrWidth-1:0] reqDest,
    input  logic [AddrWidth-1:0]    reqAddr,
    input  dataWordT                reqData,

    // Flash port
    input  logic                    flashEn,
    input  logic [AddrWidth-1:0]    flashAddr,
    input  dataWordT                flashData,

    // Writeback handshake
    output logic                    wbValid,
    input  logic                    wbReady,
    output logic [RegAddrWidth-1:0] wbDest,
    output dataWordT                wbData
);

    logic [AddrWidth-1:0]    memRdAddr;
    logic                    memWrEn;
    logic [AddrWidth-1:0]    memWrAddr;
    dataWordT                memWrData;
    dataWordT                memRdData;
    minorOpT                 heldOp;
    logic [AddrWidth-1:0]    heldAddr;
    dataWordT                heldData;
    dataWordT                loadWord;
    dataWordT                storeWord;
    logic                    bufPush;
    logic [RegAddrWidth-1:0] bufDest;
    logic                    bufFull;

    lsuControl #(
        .RegAddrWidth(RegAddrWidth),
        .AddrWidth   (AddrWidth)
    ) i_lsuControl (
        .clk      (clk),
        .arstN    (arstN),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .reqOp    (reqOp),
        .reqDest  (reqDest),
        .reqAddr  (reqAddr),
        .reqData  (reqData),
        .flashEn  (flashEn),
        .flashAddr(flashAddr),
        .flashData(flashData),
        .storeWord(storeWord),
        .memRdAddr(memRdAddr),
        .memWrEn  (memWrEn),
        .memWrAddr(memWrAddr),
        .memWrData(memWrData),
        .heldOp   (heldOp),
        .heldAddr (heldAddr),
        .heldData (heldData),
        .bufPush  (bufPush),
        .bufDest  (bufDest),
        .bufFull  (bufFull),
        .wbReady  (wbReady)
    );

    dataMemory #(
        .AddrWidth(AddrWidth)
    ) i_dataMemory (
        .clk   (clk),
        .rdAddr(memRdAddr),
        .rdData(memRdData),
        .wrEn  (memWrEn),
        .wrAddr(memWrAddr),
        .wrData(memWrData)
    );

    byteLaneAligner #(
        .AddrWidth(AddrWidth)
    ) i_byteLaneAligner (
        .op       (heldOp),
        .addr     (heldAddr),
        .memWord  (memRdData),
        .storeData(heldData),
        .loadWord (loadWord),
        .storeWord(storeWord)
    );

    writebackBuffer #(
        .RegAddrWidth(RegAddrWidth)
    ) i_writebackBuffer (
        .clk     (clk),
        .arstN   (arstN),
        .push    (bufPush),
        .pushDest(bufDest),
        .pushData(loadWord),
        .full    (bufFull),
        .wbValid (wbValid),
        .wbReady (wbReady),
        .wbDest  (wbDest),
        .wbData  (wbData)
    );

endmodule

// ==== source/lsuControl.sv ====
module lsuControl
    import memPkg::*;
    import lsuPkg::*;
#(
    parameter int RegAddrWidth = 4,
    parameter int AddrWidth    = 10
) (
    input  logic                    clk,
    input  logic                    arstN,

    // Request handshake
    input  logic                    reqValid,
    output logic                    reqReady,
    input  minorOpT                 reqOp,
    input  logic [RegAddrWidth-1:0] reqDest,
    input  logic [AddrWidth-1:0]    reqAddr,
    input  dataWordT                reqData,

    // Flash port
    input  logic                    flashEn,
    input  logic [AddrWidth-1:0]    flashAddr,
    input  dataWordT                flashData,

    // Memory control
    input  dataWordT                storeWord,
    output logic [AddrWidth-1:0]    memRdAddr,
    output logic                    memWrEn,
    output logic [AddrWidth-1:0]    memWrAddr,
    output dataWordT                memWrData,

    // Held request for the aligner
    output minorOpT                 heldOp,
    output logic [AddrWidth-1:0]    heldAddr,
    output dataWordT                heldData,

    // Writeback buffer
    output logic                    bufPush,
    output logic [RegAddrWidth-1:0] bufDest,
    input  logic                    bufFull,
    input  logic                    wbReady
);

    stageStateT stage;
    logic       readyEn;
    logic       loadDone;
    logic       storeDone;
    logic       stageFree;
    logic       reqFire;

    // Load leaves when the buffer is empty or drains this cycle
    assign loadDone  = (stage == stLoad) && (!bufFull || wbReady);
    assign storeDone = (stage == stStore) && !flashEn;

    // A held store blocks new requests, giving a bubble before the next read
    assign stageFree = (stage == stEmpty) || loadDone;
    assign reqReady  = readyEn && !flashEn && stageFree;
    assign reqFire   = reqValid && reqReady;

    // Hold off the first cycle out of reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readyEn <= 1'b0;
        end else begin
            readyEn <= 1'b1;
        end
    end

    // Stage state machine
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stage <= stEmpty;
        end else if (reqFire) begin
            stage <= isStore(reqOp) ? stStore : stLoad;
        end else if (loadDone || storeDone) begin
            stage <= stEmpty;
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (reqFire) begin
            heldOp   <= reqOp;
            heldAddr <= reqAddr;
            heldData <= reqData;
            bufDest  <= reqDest;
        end
    end

    // Stalled load keeps re-reading its own word
    assign memRdAddr = reqFire ? reqAddr : heldAddr;

    // Flash has priority on the write port
    assign memWrEn   = flashEn || storeDone;
    assign memWrAddr = flashEn ? flashAddr : heldAddr;
    assign memWrData = flashEn ? flashData : storeWord;

    assign bufPush = loadDone;

    // Flash loading is only expected while the unit is idle or loading
    noStoreDuringFlash: assert property (
        @(posedge clk) disable iff (!arstN)
        flashEn |-> (stage != stStore)
    );

    // No request enters an empty stage while flashing
    noAcceptDuringFlash: assert property (
        @(posedge clk) disable iff (!arstN)
        (flashEn && stage == stEmpty) |=> (stage == stEmpty)
    );

endmodule

// ==== source/writebackBuffer.sv ====
module writebackBuffer
    import memPkg::*;
#(
    parameter int RegAddrWidth = 4
) (
    input  logic                    clk,
    input  logic                    arstN,

    // Fill side from the request stage
    input  logic                    push,
    input  logic [RegAddrWidth-1:0] pushDest,
    input  dataWordT                pushData,
    output logic                    full,

    // Writeback handshake
    output logic                    wbValid,
    input  logic                    wbReady,
    output logic [RegAddrWidth-1:0] wbDest,
    output dataWordT                wbData
);

    logic take;

    assign take    = full && wbReady;
    assign wbValid = full;

    // Occupancy flag
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            full <= 1'b0;
        end else if (push) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    // Payload, refilled in the cycle it drains
    always_ff @(posedge clk) begin
        if (push) begin
            wbDest <= pushDest;
            wbData <= pushData;
        end
    end

    // Controller must not overwrite a result that is still waiting
    pushWhileFull: assert property (
        @(posedge clk) disable iff (!arstN)
        push |-> (!full || wbReady)
    );

endmodule

// ==== source/byteLaneAligner.sv ====
module byteLaneAligner
    import memPkg::*;
    import lsuPkg::*;
#(
    parameter int AddrWidth = 10
) (
    input  minorOpT              op,
    input  logic [AddrWidth-1:0] addr,
    input  dataWordT             memWord,
    input  dataWordT             storeData,
    output dataWordT             loadWord,
    output dataWordT             storeWord
);

    logic hiLane;

    assign hiLane = isHighLane(addr);

    // Size field only, load and store share the lane rules
    always_comb begin
        case (op[1:0])
            2'b00: begin
                // Byte access, lane picked by address bit 0
                if (hiLane) begin
                    loadWord  = {8'h00, memWord[15:8]};
                    storeWord = {storeData[7:0], memWord[7:0]};
                end else begin
                    loadWord  = {8'h00, memWord[7:0]};
                    storeWord = {memWord[15:8], storeData[7:0]};
                end
            end
            2'b01: begin
                loadWord  = memWord;
                storeWord = storeData;
            end
            default: begin
                // Double and quad are not implemented
                loadWord  = '1;
                storeWord = '1;
            end
        endcase
    end

endmodule

// ==== source/dataMemory.sv ====
module dataMemory
    import memPkg::*;
#(
    parameter int AddrWidth = 10
) (
    input  logic                 clk,

    // Read port, one cycle latency
    input  logic [AddrWidth-1:0] rdAddr,
    output dataWordT             rdData,

    // Shared write port for flash and store traffic
    input  logic                 wrEn,
    input  logic [AddrWidth-1:0] wrAddr,
    input  dataWordT             wrData
);

    dataWordT mem [MemWords];

    // Write on the edge
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wordIndex(wrAddr)] <= wrData;
        end
    end

    // Read every cycle, old data on a same-address write
    always_ff @(posedge clk) begin
        rdData <= mem[wordIndex(rdAddr)];
    end

endmodule

// ==== source/lsuPkg.sv ====
package lsuPkg;

    // Minor opcode, bits 3:2 select store (2'b01) or load, bits 1:0 the size
    typedef enum logic [3:0] {
        opLoadByte    = 4'b0000,
        opLoadWord    = 4'b0001,
        opLoadDouble  = 4'b0010,
        opLoadQuad    = 4'b0011,
        opStoreByte   = 4'b0100,
        opStoreWord   = 4'b0101,
        opStoreDouble = 4'b0110,
        opStoreQuad   = 4'b0111
    } minorOpT;

    // Request stage contents
    typedef enum logic [1:0] {
        stEmpty = 2'b00,
        stLoad  = 2'b01,
        stStore = 2'b10
    } stageStateT;

    // Any opcode outside 4'b01xx is treated as a load
    function automatic logic isStore(input minorOpT op);
        return !op[3] && op[2];
    endfunction

endpackage

// ==== source/memPkg.sv ====
package memPkg;

    // Fixed data width, the byte-lane logic is written for two lanes
    localparam int DataWidth = 16;
    localparam int MemWords  = 512;

    // Byte address is the word index plus one lane bit
    localparam int WordIdxWidth  = $clog2(MemWords);
    localparam int ByteAddrWidth = WordIdxWidth + 1;

    typedef logic [DataWidth-1:0] dataWordT;

    // Word index of a byte address
    function automatic logic [WordIdxWidth-1:0] wordIndex(input logic [ByteAddrWidth-1:0] byteAddr);
        return byteAddr[ByteAddrWidth-1:1];
    endfunction

    // High lane is selected by an odd address
    function automatic logic isHighLane(input logic [ByteAddrWidth-1:0] byteAddr);
        return byteAddr[0];
    endfunction

endpackage
